// File: verilog/uart_cfg_pkg.sv
`default_nettype none

package uart_cfg_pkg;

	// one clock, one rate: 25 MHz clock, 1.5625 Mbaud
	localparam int CLKS_PER_BIT = 16;
	// sampling point measured from the start edge
	localparam int HALF_BIT = CLKS_PER_BIT / 2;

	// start, 8 data, stop
	localparam int FRAME_BITS = 10;

	// per direction buffering
	localparam int FIFO_DEPTH = 8;
	localparam int FIFO_AW = 3;

	// wide enough for CLKS_PER_BIT - 1
	localparam int BIT_CNT_W = 5;

endpackage

`default_nettype wire

// File: verilog/uart_types_pkg.sv
`default_nettype none

package uart_types_pkg;
	import uart_cfg_pkg::*;

	typedef logic [7:0] uart_byte_t;
	typedef logic [FIFO_AW:0] fifo_level_t;
	typedef logic [BIT_CNT_W-1:0] bit_cnt_t;

	// sticky receive errors, cleared only by reset
	typedef struct packed {
		logic frame_err;
		logic overrun;
	} uart_status_t;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_LOAD,
		TX_SHIFT
	} tx_state_e;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_e;

	// four-phase handshake, shared by both host channels
	typedef enum logic [1:0] {
		HS_IDLE,
		HS_ACK,
		HS_WAIT_DROP
	} hs_state_e;

endpackage

`default_nettype wire

// File: verilog/uart_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module uart_fifo
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
(
	input wire clk_in,
	input wire rst_n,
	input wire push,
	input wire uart_byte_t push_data,
	input wire pop,
	output uart_byte_t head,
	output logic empty,
	output logic full,
	output fifo_level_t level
);

	uart_byte_t mem [FIFO_DEPTH];
	logic [FIFO_AW-1:0] wr_ptr;
	logic [FIFO_AW-1:0] rd_ptr;
	fifo_level_t count;
	logic do_push;
	logic do_pop;

	// requests past the limits are dropped
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// first word fall through
	assign head = mem[rd_ptr];
	assign empty = (count == '0);
	assign full = (count == fifo_level_t'(FIFO_DEPTH));
	assign level = count;

	always_ff @(posedge clk_in) begin
		if (do_push) begin
			mem[wr_ptr] <= push_data;
		end
	end

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// writers and readers are expected to honour full and empty
	a_push_full: assert property (@(posedge clk_in) disable iff (!rst_n) full |-> !push)
		else $error("push into a full fifo");
	a_pop_empty: assert property (@(posedge clk_in) disable iff (!rst_n) empty |-> !pop)
		else $error("pop from an empty fifo");

endmodule

`default_nettype wire

// File: verilog/uart_host_port.sv
`timescale 1ns/1ps
`default_nettype none

module uart_host_port
	import uart_types_pkg::*;
(
	input wire clk_in,
	input wire rst_n,
	input wire tx_req,
	input wire uart_byte_t tx_data,
	output logic tx_ack,
	input wire rx_req,
	output uart_byte_t rx_data,
	output logic rx_ack,
	output logic txf_push,
	output uart_byte_t txf_data,
	input wire txf_full,
	output logic rxf_pop,
	input wire uart_byte_t rxf_head,
	input wire rxf_empty
);

	hs_state_e tx_state;
	hs_state_e rx_state;
	uart_byte_t rx_hold;

	// common four-phase sequencing for both channels
	function automatic hs_state_e hs_next(input hs_state_e cur, input logic req,
		input logic take);
		hs_state_e nxt;
		nxt = cur;
		case (cur)
			HS_IDLE: if (take) nxt = HS_ACK;
			HS_ACK: if (!req) nxt = HS_WAIT_DROP;
			default: nxt = HS_IDLE;
		endcase
		return nxt;
	endfunction

	// write side, push lands on the edge that raises the ack
	assign txf_push = (tx_state == HS_IDLE) && tx_req && !txf_full;
	assign txf_data = tx_data;
	assign tx_ack = (tx_state != HS_IDLE);

	// read side, head goes into the hold register
	assign rxf_pop = (rx_state == HS_IDLE) && rx_req && !rxf_empty;
	assign rx_data = rx_hold;
	assign rx_ack = (rx_state != HS_IDLE);

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			tx_state <= HS_IDLE;
			rx_state <= HS_IDLE;
		end else begin
			tx_state <= hs_next(tx_state, tx_req, txf_push);
			rx_state <= hs_next(rx_state, rx_req, rxf_pop);
		end
	end

	// stays valid while the ack is up
	always_ff @(posedge clk_in) begin
		if (rxf_pop) begin
			rx_hold <= rxf_head;
		end
	end

	a_tx_ack_req: assert property (@(posedge clk_in) disable iff (!rst_n)
		$rose(tx_ack) |-> $past(tx_req))
		else $error("tx_ack rose without tx_req");
	a_rx_ack_req: assert property (@(posedge clk_in) disable iff (!rst_n)
		$rose(rx_ack) |-> $past(rx_req))
		else $error("rx_ack rose without rx_req");

endmodule

`default_nettype wire

// File: verilog/uart_transmitter.sv
`timescale 1ns/1ps
`default_nettype none

module uart_transmitter
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
(
	input wire clk_in,
	input wire rst_n,
	input wire uart_byte_t fifo_head,
	input wire fifo_empty,
	output logic fifo_pop,
	output logic tx
);

	tx_state_e state;
	// stop, data lsb first, start
	logic [FRAME_BITS-1:0] shreg;
	bit_cnt_t bit_timer;
	logic [3:0] bit_idx;
	logic bit_end;

	assign bit_end = (bit_timer == bit_cnt_t'(CLKS_PER_BIT - 1));

	// byte is taken in the load cycle
	assign fifo_pop = (state == TX_LOAD);

	// line is the low end of the shift register, ones fill in behind
	assign tx = shreg[0];

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			state <= TX_IDLE;
			shreg <= '1;
			bit_timer <= '0;
			bit_idx <= '0;
		end else begin
			case (state)
				TX_IDLE: begin
					if (!fifo_empty) begin
						state <= TX_LOAD;
					end
				end
				TX_LOAD: begin
					shreg <= {1'b1, fifo_head, 1'b0};
					bit_timer <= '0;
					bit_idx <= '0;
					state <= TX_SHIFT;
				end
				TX_SHIFT: begin
					if (bit_end) begin
						bit_timer <= '0;
						shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
						// extra idle-high bit time after the stop bit
						if (bit_idx == 4'(FRAME_BITS)) begin
							state <= TX_IDLE;
						end else begin
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				default: begin
					state <= TX_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module uart_receiver
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
(
	input wire clk_in,
	input wire rst_n,
	input wire rx,
	input wire fifo_full,
	output logic fifo_push,
	output uart_byte_t fifo_data,
	output uart_status_t status
);

	logic rx_meta;
	logic rx_sync;
	rx_state_e state;
	bit_cnt_t bit_timer;
	logic [2:0] bit_idx;
	uart_byte_t shift_data;
	uart_status_t status_q;
	logic half_end;
	logic bit_end;

	assign half_end = (bit_timer == bit_cnt_t'(HALF_BIT - 1));
	assign bit_end = (bit_timer == bit_cnt_t'(CLKS_PER_BIT - 1));
	assign fifo_data = shift_data;
	assign status = status_q;

	// line idles high
	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge clk_in) begin
		if (!rst_n) begin
			state <= RX_IDLE;
			bit_timer <= '0;
			bit_idx <= '0;
			fifo_push <= 1'b0;
			status_q <= '0;
		end else begin
			fifo_push <= 1'b0;
			case (state)
				RX_IDLE: begin
					bit_timer <= '0;
					if (!rx_sync) begin
						state <= RX_START;
					end
				end
				RX_START: begin
					if (half_end) begin
						bit_timer <= '0;
						bit_idx <= '0;
						// start bit gone at mid-bit means a glitch
						state <= rx_sync ? RX_IDLE : RX_DATA;
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				RX_DATA: begin
					if (bit_end) begin
						bit_timer <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7) begin
							state <= RX_STOP;
						end
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				RX_STOP: begin
					if (bit_end) begin
						bit_timer <= '0;
						state <= RX_IDLE;
						if (!rx_sync) begin
							status_q.frame_err <= 1'b1;
						end else if (fifo_full) begin
							status_q.overrun <= 1'b1;
						end else begin
							fifo_push <= 1'b1;
						end
					end else begin
						bit_timer <= bit_timer + 1'b1;
					end
				end
				default: begin
					state <= RX_IDLE;
				end
			endcase
		end
	end

	// data arrives lsb first
	always_ff @(posedge clk_in) begin
		if (state == RX_DATA && bit_end) begin
			shift_data <= {rx_sync, shift_data[7:1]};
		end
	end

endmodule

`default_nettype wire

// File: verilog/uart_driver.sv
`timescale 1ns/1ps
`default_nettype none

module uart_driver
	import uart_types_pkg::*;
(
	input wire clk_in,
	input wire rst_n,
	input wire tx_req,
	input wire uart_byte_t tx_data,
	output logic tx_ack,
	input wire rx_req,
	output uart_byte_t rx_data,
	output logic rx_ack,
	output logic tx,
	input wire rx,
	output uart_status_t status
);

	// transmit path
	logic txf_push;
	logic txf_pop;
	logic txf_full;
	logic txf_empty;
	uart_byte_t txf_data;
	uart_byte_t txf_head;

	// receive path
	logic rxf_push;
	logic rxf_pop;
	logic rxf_full;
	logic rxf_empty;
	uart_byte_t rxf_data;
	uart_byte_t rxf_head;

	uart_host_port u_host_port (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.tx_req(tx_req),
		.tx_data(tx_data),
		.tx_ack(tx_ack),
		.rx_req(rx_req),
		.rx_data(rx_data),
		.rx_ack(rx_ack),
		.txf_push(txf_push),
		.txf_data(txf_data),
		.txf_full(txf_full),
		.rxf_pop(rxf_pop),
		.rxf_head(rxf_head),
		.rxf_empty(rxf_empty)
	);

	uart_fifo u_tx_fifo (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.push(txf_push),
		.push_data(txf_data),
		.pop(txf_pop),
		.head(txf_head),
		.empty(txf_empty),
		.full(txf_full),
		.level()
	);

	uart_fifo u_rx_fifo (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.push(rxf_push),
		.push_data(rxf_data),
		.pop(rxf_pop),
		.head(rxf_head),
		.empty(rxf_empty),
		.full(rxf_full),
		.level()
	);

	uart_transmitter u_transmitter (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.fifo_head(txf_head),
		.fifo_empty(txf_empty),
		.fifo_pop(txf_pop),
		.tx(tx)
	);

	uart_receiver u_receiver (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.rx(rx),
		.fifo_full(rxf_full),
		.fifo_push(rxf_push),
		.fifo_data(rxf_data),
		.status(status)
	);

endmodule

`default_nettype wire

// File: sim/uart_driver_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_driver_tb
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
();

	localparam int N_TX = 20;
	localparam int N_BP = 12;
	localparam int N_RX = 20;
	localparam int N_OVR = FIFO_DEPTH + 2;
	localparam int FRAME_CYCLES = FRAME_BITS * CLKS_PER_BIT;
	localparam int TOTAL_FRAMES = N_TX + N_BP + N_RX + 2 + N_OVR;
	localparam int WATCHDOG_NS = TOTAL_FRAMES * FRAME_CYCLES * 40 * 2;

	logic clk_in;
	logic rst_n;
	logic tx_req;
	uart_byte_t tx_data;
	logic tx_ack;
	logic rx_req;
	uart_byte_t rx_data;
	logic rx_ack;
	logic tx;
	logic rx;
	uart_status_t status;

	// reference model
	uart_byte_t tx_expect[$];
	uart_byte_t rx_expect[$];
	int tx_frames = 0;
	int ack_cycles = 0;
	int errors = 0;
	int passed = 0;
	int failed = 0;

	uart_driver u_uart_driver (
		.clk_in(clk_in),
		.rst_n(rst_n),
		.tx_req(tx_req),
		.tx_data(tx_data),
		.tx_ack(tx_ack),
		.rx_req(rx_req),
		.rx_data(rx_data),
		.rx_ack(rx_ack),
		.tx(tx),
		.rx(rx),
		.status(status)
	);

	always #20 clk_in = ~clk_in;

	task automatic flag_error(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		errors++;
	endtask

	task automatic report_test(input string name, input int errs_before);
		if (errors == errs_before) begin
			passed++;
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	// host side of the transmit handshake
	task automatic write_byte(input uart_byte_t b);
		@(posedge clk_in);
		#2;
		tx_data = b;
		tx_req = 1'b1;
		tx_expect.push_back(b);
		// clock cycles from the request to the ack
		ack_cycles = 0;
		@(negedge clk_in);
		while (tx_ack !== 1'b1) begin
			@(negedge clk_in);
			ack_cycles++;
		end
		@(posedge clk_in);
		#2;
		tx_req = 1'b0;
		do @(negedge clk_in); while (tx_ack !== 1'b0);
	endtask

	// host side of the receive handshake with a cycle limit
	task automatic read_byte(input int limit, output logic got, output uart_byte_t val);
		int waited;
		got = 1'b0;
		val = '0;
		waited = 0;
		@(posedge clk_in);
		#2;
		rx_req = 1'b1;
		while (!got && waited < limit) begin
			@(negedge clk_in);
			if (rx_ack === 1'b1) begin
				got = 1'b1;
				val = rx_data;
			end
			waited++;
		end
		@(posedge clk_in);
		#2;
		rx_req = 1'b0;
		while (rx_ack !== 1'b0) @(negedge clk_in);
	endtask

	task automatic expect_read(input int limit);
		logic got;
		uart_byte_t val;
		uart_byte_t want;
		read_byte(limit, got, val);
		if (!got) begin
			$display("no byte arrived on the receive channel within %0d cycles", limit);
			errors++;
		end else if (rx_expect.size() == 0) begin
			flag_error($sformatf("read 0x%02h with no byte expected", val));
		end else begin
			want = rx_expect.pop_front();
			if (val !== want) begin
				flag_error($sformatf("rx_data 0x%02h, expected 0x%02h", val, want));
			end
		end
	endtask

	task automatic expect_no_read(input int limit);
		logic got;
		uart_byte_t val;
		read_byte(limit, got, val);
		if (got) begin
			flag_error($sformatf("extra byte 0x%02h read back", val));
		end
	endtask

	// line encoder with an optional low stop bit
	task automatic send_frame(input uart_byte_t b, input logic bad_stop);
		logic [FRAME_BITS-1:0] bits;
		bits = {~bad_stop, b, 1'b0};
		@(posedge clk_in);
		#2;
		for (int i = 0; i < FRAME_BITS; i++) begin
			rx = bits[i];
			repeat (CLKS_PER_BIT) @(posedge clk_in);
			#2;
		end
		// at least one idle bit before the next start edge
		rx = 1'b1;
		repeat (CLKS_PER_BIT) @(posedge clk_in);
	endtask

	task automatic wait_tx_drained();
		while (tx_expect.size() != 0) @(negedge clk_in);
		// room for a repeated frame to show up
		repeat (2 * FRAME_CYCLES) @(negedge clk_in);
	endtask

	// line decoder checking each bit at its first, middle and last cycle
	initial begin : tx_decoder
		logic [FRAME_BITS-1:0] bits;
		logic first;
		logic mid;
		logic last;
		uart_byte_t want;
		forever begin
			@(negedge clk_in);
			if (rst_n === 1'b1 && tx === 1'b0) begin
				for (int b = 0; b < FRAME_BITS; b++) begin
					for (int c = 0; c < CLKS_PER_BIT; c++) begin
						if (c == 0)
							first = tx;
						if (c == HALF_BIT)
							mid = tx;
						if (c == CLKS_PER_BIT - 1)
							last = tx;
						@(negedge clk_in);
					end
					bits[b] = mid;
					if (first !== mid || last !== mid) begin
						flag_error($sformatf("tx bit %0d not held for a full bit time", b));
					end
				end
				if (bits[0] !== 1'b0) begin
					flag_error("tx start bit not low at mid-bit");
				end
				if (bits[FRAME_BITS-1] !== 1'b1) begin
					flag_error("tx stop bit not high");
				end
				if (tx_expect.size() == 0) begin
					flag_error($sformatf("tx frame 0x%02h with no byte pending", bits[8:1]));
				end else begin
					want = tx_expect.pop_front();
					if (bits[8:1] !== want) begin
						flag_error($sformatf("tx frame 0x%02h, expected 0x%02h",
							bits[8:1], want));
					end
				end
				tx_frames++;
			end
		end
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("run did not finish within %0d ns and timed out", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	initial begin : main
		int mark;
		int frames_mark;
		int max_wait;
		uart_byte_t b;
		clk_in = 1'b0;
		rst_n = 1'b0;
		tx_req = 1'b0;
		tx_data = '0;
		rx_req = 1'b0;
		rx = 1'b1;
		void'($urandom(32'hdd78597a));
		repeat (5) @(posedge clk_in);
		#2;
		rst_n = 1'b1;

		// idle state after reset
		mark = errors;
		@(negedge clk_in);
		if (tx !== 1'b1 || tx_ack !== 1'b0 || rx_ack !== 1'b0 || status !== '0) begin
			flag_error($sformatf("after reset tx=%b tx_ack=%b rx_ack=%b status=%b",
				tx, tx_ack, rx_ack, status));
		end
		report_test("1 reset state", mark);

		// random bytes with gaps
		mark = errors;
		frames_mark = tx_frames;
		for (int i = 0; i < N_TX; i++) begin
			write_byte(8'($urandom_range(0, 255)));
			repeat ($urandom_range(0, 4)) @(posedge clk_in);
		end
		wait_tx_drained();
		if (tx_frames - frames_mark != N_TX) begin
			flag_error($sformatf("%0d tx frames, expected %0d",
				tx_frames - frames_mark, N_TX));
		end
		report_test("2 transmit", mark);

		// back to back writes beyond the FIFO depth
		mark = errors;
		frames_mark = tx_frames;
		max_wait = 0;
		for (int i = 0; i < N_BP; i++) begin
			write_byte(8'($urandom_range(0, 255)));
			// FIFO is empty after the drain
			if (i == 0 && ack_cycles != 1) begin
				flag_error($sformatf("first tx_ack after %0d cycles, expected 1",
					ack_cycles));
			end
			if (ack_cycles > max_wait) begin
				max_wait = ack_cycles;
			end
		end
		if (max_wait <= 1) begin
			flag_error("tx_ack never stalled with more bytes than the FIFO holds");
		end
		wait_tx_drained();
		if (tx_frames - frames_mark != N_BP) begin
			flag_error($sformatf("%0d tx frames, expected %0d",
				tx_frames - frames_mark, N_BP));
		end
		report_test("3 transmit back-pressure", mark);

		// line and host run side by side
		mark = errors;
		fork
			begin
				for (int i = 0; i < N_RX; i++) begin
					b = 8'($urandom_range(0, 255));
					rx_expect.push_back(b);
					send_frame(b, 1'b0);
					repeat ($urandom_range(0, 2 * CLKS_PER_BIT)) @(posedge clk_in);
				end
			end
			begin
				for (int i = 0; i < N_RX; i++) begin
					expect_read(4 * FRAME_CYCLES);
					repeat ($urandom_range(0, 4)) @(posedge clk_in);
				end
			end
		join
		@(negedge clk_in);
		if (status !== '0) begin
			flag_error($sformatf("status %b after clean frames", status));
		end
		report_test("4 receive", mark);

		// bad stop bit followed by a good frame
		mark = errors;
		send_frame(8'($urandom_range(0, 255)), 1'b1);
		b = 8'($urandom_range(0, 255));
		rx_expect.push_back(b);
		send_frame(b, 1'b0);
		expect_read(4 * FRAME_CYCLES);
		expect_no_read(2 * FRAME_CYCLES);
		if (status.frame_err !== 1'b1 || status.overrun !== 1'b0) begin
			flag_error($sformatf("status %b after framing error", status));
		end
		report_test("5 framing error", mark);

		// fill the receive FIFO past its depth
		mark = errors;
		for (int i = 0; i < N_OVR; i++) begin
			b = 8'($urandom_range(0, 255));
			if (i < FIFO_DEPTH) begin
				rx_expect.push_back(b);
			end
			send_frame(b, 1'b0);
		end
		for (int i = 0; i < FIFO_DEPTH; i++) begin
			expect_read(4 * FRAME_CYCLES);
		end
		expect_no_read(2 * FRAME_CYCLES);
		if (status.overrun !== 1'b1) begin
			flag_error($sformatf("status %b after overrun", status));
		end
		report_test("6 overrun", mark);

		$display("tests passed: %0d, failed: %0d", passed, failed);
		if (failed == 0 && errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
verilog/uart_cfg_pkg.sv
verilog/uart_types_pkg.sv
verilog/uart_fifo.sv
verilog/uart_host_port.sv
verilog/uart_transmitter.sv
verilog/uart_receiver.sv
verilog/uart_driver.sv
sim/uart_driver_tb.sv

// File: Bender.yml
package:
  name: uart_driver

sources:
  - verilog/uart_cfg_pkg.sv
  - verilog/uart_types_pkg.sv
  - verilog/uart_fifo.sv
  - verilog/uart_host_port.sv
  - verilog/uart_transmitter.sv
  - verilog/uart_receiver.sv
  - verilog/uart_driver.sv
  - target: simulation
    files:
      - sim/uart_driver_tb.sv
